//--- design/fp_pkg.sv
package fp_pkg;

  // ------------------------------
  // Formats and widths
  // ------------------------------
  typedef enum logic [0:0] {
    FP32 = 1'b0,
    FP16 = 1'b1
  } fp_format_e;

  localparam int unsigned WORD_WIDTH = 32;
  localparam int unsigned FP16_WIDTH = 16;
  localparam int unsigned NUM_LANES  = WORD_WIDTH / FP16_WIDTH; // FP16 values per word

  // Field widths for the lane decode
  localparam int unsigned FP32_EXP_BITS = 8;
  localparam int unsigned FP32_MAN_BITS = 23;
  localparam int unsigned FP16_EXP_BITS = 5;
  localparam int unsigned FP16_MAN_BITS = 10;

  typedef logic [WORD_WIDTH-1:0] fp_word_t;
  typedef logic [FP16_WIDTH-1:0] fp16_t;
  typedef logic [WORD_WIDTH-2:0] fp_mag_t;  // Magnitude of the widest format

  // ------------------------------
  // Status flags
  // ------------------------------
  typedef struct packed {
    logic nv;  // Invalid operation
    logic dz;  // Divide by zero
    logic of;  // Overflow
    logic uf;  // Underflow
    logic nx;  // Inexact
  } status_t;

  // Canonical quiet NaNs, positive sign
  localparam fp_word_t CANON_NAN_FP32 = 32'h7fc0_0000;
  localparam fp16_t    CANON_NAN_FP16 = 16'h7e00;

endpackage

//--- design/slice_pkg.sv
package slice_pkg;

  // ------------------------------
  // Operations
  // ------------------------------
  typedef enum logic [2:0] {
    MIN   = 3'd0,
    MAX   = 3'd1,
    SGNJ  = 3'd2,  // Sign of b
    SGNJN = 3'd3,  // Negated sign of b
    SGNJX = 3'd4   // Xor of both signs
  } operation_e;

  // ------------------------------
  // Lane request and response
  // ------------------------------
  typedef struct packed {
    operation_e         op;
    fp_pkg::fp_format_e fmt;
    logic               is_vector;
    logic               mask;
    fp_pkg::fp_word_t   a;
    fp_pkg::fp_word_t   b;
  } lane_req_t;

  // Format and vector flag ride along for result packing
  typedef struct packed {
    fp_pkg::fp_word_t   result;
    fp_pkg::status_t    status;
    fp_pkg::fp_format_e fmt;
    logic               is_vector;
    logic               mask;
  } lane_rsp_t;

endpackage

//--- design/lane_dispatch.sv
`timescale 1ns/1ps

module lane_dispatch (
  input  fp_pkg::fp_word_t                             operand_a_i,
  input  fp_pkg::fp_word_t                             operand_b_i,
  input  slice_pkg::operation_e                        op_i,
  input  fp_pkg::fp_format_e                           fmt_i,
  input  logic                                         vectorial_op_i,
  input  logic [fp_pkg::NUM_LANES-1:0]                 simd_mask_i,
  // Upstream handshake
  input  logic                                         in_valid_i,
  output logic                                         in_ready_o,
  // Lane side
  output slice_pkg::lane_req_t [fp_pkg::NUM_LANES-1:0] lane_req_o,
  output logic [fp_pkg::NUM_LANES-1:0]                 lane_valid_o,
  input  logic [fp_pkg::NUM_LANES-1:0]                 lane_ready_i
);

  logic is_vector;

  // Only FP16 words can hold more than one value
  assign is_vector = vectorial_op_i & (fmt_i == fp_pkg::FP16);

  // ------------------------------
  // Operand slicing
  // ------------------------------
  always_comb begin : slice_operands
    for (int unsigned lane = 0; lane < fp_pkg::NUM_LANES; lane++) begin
      lane_req_o[lane].op        = op_i;
      lane_req_o[lane].fmt       = fmt_i;
      lane_req_o[lane].is_vector = is_vector;
      lane_req_o[lane].mask      = simd_mask_i[lane];
      // Upper bits are ignored by the lane
      lane_req_o[lane].a         = operand_a_i >> (lane * fp_pkg::FP16_WIDTH);
      lane_req_o[lane].b         = operand_b_i >> (lane * fp_pkg::FP16_WIDTH);
    end
  end

  // ------------------------------
  // Handshake gating
  // ------------------------------
  assign lane_valid_o[0] = in_valid_i;  // Lane 0 sees every word

  // Upper lane takes a vector half only in the cycle lane 0 takes its own
  assign lane_valid_o[1] = in_valid_i & is_vector & lane_ready_i[0];

  // A vector word needs room in both lanes
  assign in_ready_o = lane_ready_i[0] & (lane_ready_i[1] | ~is_vector);

endmodule

//--- design/minmax_lane.sv
`timescale 1ns/1ps

module minmax_lane #(
  parameter int unsigned NumPipeRegs = 0,
  parameter int unsigned TagWidth    = 1
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  slice_pkg::lane_req_t req_i,
  input  logic [TagWidth-1:0]  tag_i,
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  input  logic                 flush_i,
  output slice_pkg::lane_rsp_t rsp_o,
  output logic [TagWidth-1:0]  tag_o,
  output logic                 out_valid_o,
  input  logic                 out_ready_i,
  output logic                 busy_o
);

  logic             is_fp16;
  logic             sign_a, sign_b;
  fp_pkg::fp_mag_t  mag_a, mag_b, canon_mag;
  logic             nan_a, nan_b, snan_a, snan_b;
  logic             a_lt_b, pick_a;
  logic             res_sign;
  fp_pkg::fp_mag_t  res_mag;
  fp_pkg::status_t  op_status;
  fp_pkg::fp_word_t op_result;

  // Returns {is NaN, is signaling NaN} in the given format
  function automatic logic [1:0] nan_flags(input fp_pkg::fp_word_t w, input logic fp16);
    logic exp_ones;
    logic man_nonzero;
    logic quiet;
    if (fp16) begin
      exp_ones    = &w[fp_pkg::FP16_MAN_BITS +: fp_pkg::FP16_EXP_BITS];
      man_nonzero = |w[fp_pkg::FP16_MAN_BITS-1:0];
      quiet       = w[fp_pkg::FP16_MAN_BITS-1];
    end else begin
      exp_ones    = &w[fp_pkg::FP32_MAN_BITS +: fp_pkg::FP32_EXP_BITS];
      man_nonzero = |w[fp_pkg::FP32_MAN_BITS-1:0];
      quiet       = w[fp_pkg::FP32_MAN_BITS-1];
    end
    return {exp_ones & man_nonzero, exp_ones & man_nonzero & ~quiet};
  endfunction

  // ------------------------------
  // Operand decode
  // ------------------------------
  assign is_fp16 = (req_i.fmt == fp_pkg::FP16);

  assign sign_a = is_fp16 ? req_i.a[fp_pkg::FP16_WIDTH-1] : req_i.a[fp_pkg::WORD_WIDTH-1];
  assign sign_b = is_fp16 ? req_i.b[fp_pkg::FP16_WIDTH-1] : req_i.b[fp_pkg::WORD_WIDTH-1];
  assign mag_a  = is_fp16 ? fp_pkg::fp_mag_t'(req_i.a[fp_pkg::FP16_WIDTH-2:0])
                          : req_i.a[fp_pkg::WORD_WIDTH-2:0];
  assign mag_b  = is_fp16 ? fp_pkg::fp_mag_t'(req_i.b[fp_pkg::FP16_WIDTH-2:0])
                          : req_i.b[fp_pkg::WORD_WIDTH-2:0];

  assign canon_mag = is_fp16 ? fp_pkg::fp_mag_t'(fp_pkg::CANON_NAN_FP16[fp_pkg::FP16_WIDTH-2:0])
                             : fp_pkg::CANON_NAN_FP32[fp_pkg::WORD_WIDTH-2:0];

  assign {nan_a, snan_a} = nan_flags(req_i.a, is_fp16);
  assign {nan_b, snan_b} = nan_flags(req_i.b, is_fp16);

  // Sign-magnitude order, -0 sorts below +0
  assign a_lt_b = (sign_a != sign_b) ? sign_a
                : (sign_a ? (mag_a > mag_b) : (mag_a < mag_b));
  assign pick_a = (req_i.op == slice_pkg::MIN) ? a_lt_b : ~a_lt_b;

  // ------------------------------
  // Operation
  // ------------------------------
  always_comb begin : operation
    res_sign  = sign_a;
    res_mag   = mag_a;
    op_status = '0;
    case (req_i.op)
      slice_pkg::MIN, slice_pkg::MAX: begin
        op_status.nv = snan_a | snan_b;
        if (nan_a && nan_b) begin
          res_sign = 1'b0;
          res_mag  = canon_mag;
        end else if (nan_a || (!nan_b && !pick_a)) begin
          res_sign = sign_b;  // NaN a or b wins the compare
          res_mag  = mag_b;
        end
      end
      slice_pkg::SGNJ:  res_sign = sign_b;
      slice_pkg::SGNJN: res_sign = ~sign_b;
      slice_pkg::SGNJX: res_sign = sign_a ^ sign_b;
      default:          res_sign = sign_a;
    endcase
  end

  // FP16 lives in the low half, upper half left boxed
  assign op_result = is_fp16 ? {{fp_pkg::FP16_WIDTH{1'b1}}, res_sign,
                                res_mag[fp_pkg::FP16_WIDTH-2:0]}
                             : {res_sign, res_mag};

  // ------------------------------
  // Pipeline
  // ------------------------------
  // Index i holds the item after i register stages
  slice_pkg::lane_rsp_t [0:NumPipeRegs]               pipe_rsp_q;
  logic                 [0:NumPipeRegs][TagWidth-1:0] pipe_tag_q;
  logic                 [0:NumPipeRegs]               pipe_valid_q;
  logic                 [0:NumPipeRegs]               pipe_ready;

  assign pipe_rsp_q[0] = '{
    result:    op_result,
    status:    op_status,
    fmt:       req_i.fmt,
    is_vector: req_i.is_vector,
    mask:      req_i.mask
  };
  assign pipe_tag_q[0]   = tag_i;
  assign pipe_valid_q[0] = in_valid_i;

  for (genvar i = 0; i < NumPipeRegs; i++) begin : gen_stage
    // Advance when downstream takes the item or only holds a bubble
    assign pipe_ready[i] = pipe_ready[i+1] | ~pipe_valid_q[i+1];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        pipe_valid_q[i+1] <= 1'b0;
      end else if (flush_i) begin
        pipe_valid_q[i+1] <= 1'b0;
      end else if (pipe_ready[i]) begin
        pipe_valid_q[i+1] <= pipe_valid_q[i];
      end
    end

    always_ff @(posedge clk_i) begin
      if (pipe_ready[i] && pipe_valid_q[i]) begin
        pipe_rsp_q[i+1] <= pipe_rsp_q[i];
        pipe_tag_q[i+1] <= pipe_tag_q[i];
      end
    end
  end

  assign pipe_ready[NumPipeRegs] = out_ready_i;  // Driven by the downstream side
  assign in_ready_o              = pipe_ready[0];
  assign out_valid_o             = pipe_valid_q[NumPipeRegs];
  assign rsp_o                   = pipe_rsp_q[NumPipeRegs];
  assign tag_o                   = pipe_tag_q[NumPipeRegs];

  // Registered stages only
  always_comb begin : busy_collect
    busy_o = 1'b0;
    for (int unsigned i = 1; i <= NumPipeRegs; i++) begin
      busy_o |= pipe_valid_q[i];
    end
  end

endmodule

//--- design/result_pack.sv
`timescale 1ns/1ps

module result_pack (
  input  slice_pkg::lane_rsp_t [fp_pkg::NUM_LANES-1:0] lane_rsp_i,
  input  logic [fp_pkg::NUM_LANES-1:0]                 lane_valid_i,
  output logic [fp_pkg::NUM_LANES-1:0]                 lane_ready_o,
  input  logic [fp_pkg::NUM_LANES-1:0]                 lane_busy_i,
  // Downstream side
  output fp_pkg::fp_word_t                             result_o,
  output fp_pkg::status_t                              status_o,
  output logic                                         out_valid_o,
  input  logic                                         out_ready_i,
  output logic                                         busy_o
);

  logic          is_vector;
  logic          pair_valid;
  fp_pkg::fp16_t lower_half;
  fp_pkg::fp16_t upper_half;

  // Lane 0 carries the word's format and vector flag
  assign is_vector  = lane_rsp_i[0].is_vector;
  assign pair_valid = is_vector & lane_valid_i[0] & lane_valid_i[1];

  // ------------------------------
  // Handshake
  // ------------------------------
  assign out_valid_o     = lane_valid_i[0];
  assign lane_ready_o[0] = out_ready_i;
  // Pop the upper lane only together with its partner in lane 0
  assign lane_ready_o[1] = out_ready_i & pair_valid;
  assign busy_o          = |lane_busy_i;

  // ------------------------------
  // Result assembly
  // ------------------------------
  assign lower_half = lane_rsp_i[0].result[fp_pkg::FP16_WIDTH-1:0];
  assign upper_half = is_vector ? lane_rsp_i[1].result[fp_pkg::FP16_WIDTH-1:0]
                                : '1;  // NaN-box for scalar FP16

  assign result_o = (lane_rsp_i[0].fmt == fp_pkg::FP32) ? lane_rsp_i[0].result
                                                         : {upper_half, lower_half};

  // Masked lanes drop out of the flag OR
  always_comb begin : status_collapse
    status_o = lane_rsp_i[0].status & {$bits(fp_pkg::status_t){lane_rsp_i[0].mask}};
    if (is_vector) begin
      status_o |= lane_rsp_i[1].status & {$bits(fp_pkg::status_t){lane_rsp_i[1].mask}};
    end
  end

endmodule

//--- design/fp_minmax_slice.sv
`timescale 1ns/1ps

module fp_minmax_slice #(
  parameter int unsigned NumPipeRegs = 0,
  parameter int unsigned TagWidth    = 1
) (
  input  logic                         clk_i,
  input  logic                         arst_n_i,
  // Input word
  input  fp_pkg::fp_word_t             operand_a_i,
  input  fp_pkg::fp_word_t             operand_b_i,
  input  slice_pkg::operation_e        op_i,
  input  fp_pkg::fp_format_e           fmt_i,
  input  logic                         vectorial_op_i,
  input  logic [TagWidth-1:0]          tag_i,
  input  logic [fp_pkg::NUM_LANES-1:0] simd_mask_i,
  input  logic                         in_valid_i,
  output logic                         in_ready_o,
  input  logic                         flush_i,
  // Output word
  output fp_pkg::fp_word_t             result_o,
  output fp_pkg::status_t              status_o,
  output logic [TagWidth-1:0]          tag_o,
  output logic                         out_valid_o,
  input  logic                         out_ready_i,
  output logic                         busy_o
);

  slice_pkg::lane_req_t [fp_pkg::NUM_LANES-1:0]               lane_req;
  slice_pkg::lane_rsp_t [fp_pkg::NUM_LANES-1:0]               lane_rsp;
  logic                 [fp_pkg::NUM_LANES-1:0]               lane_in_valid, lane_in_ready;
  logic                 [fp_pkg::NUM_LANES-1:0]               lane_out_valid, lane_out_ready;
  logic                 [fp_pkg::NUM_LANES-1:0]               lane_busy;
  logic                 [fp_pkg::NUM_LANES-1:0][TagWidth-1:0] lane_tag;

  lane_dispatch i_lane_dispatch (
    .operand_a_i,
    .operand_b_i,
    .op_i,
    .fmt_i,
    .vectorial_op_i,
    .simd_mask_i,
    .in_valid_i,
    .in_ready_o,
    .lane_req_o   ( lane_req      ),
    .lane_valid_o ( lane_in_valid ),
    .lane_ready_i ( lane_in_ready )
  );

  // ------------------------------
  // Lanes
  // ------------------------------
  for (genvar lane = 0; lane < fp_pkg::NUM_LANES; lane++) begin : gen_lanes
    minmax_lane #(
      .NumPipeRegs ( NumPipeRegs ),
      .TagWidth    ( TagWidth    )
    ) i_minmax_lane (
      .clk_i,
      .arst_n_i,
      .req_i       ( lane_req[lane]       ),
      .tag_i,
      .in_valid_i  ( lane_in_valid[lane]  ),
      .in_ready_o  ( lane_in_ready[lane]  ),
      .flush_i,
      .rsp_o       ( lane_rsp[lane]       ),
      .tag_o       ( lane_tag[lane]       ),
      .out_valid_o ( lane_out_valid[lane] ),
      .out_ready_i ( lane_out_ready[lane] ),
      .busy_o      ( lane_busy[lane]      )
    );
  end

  result_pack i_result_pack (
    .lane_rsp_i   ( lane_rsp       ),
    .lane_valid_i ( lane_out_valid ),
    .lane_ready_o ( lane_out_ready ),
    .lane_busy_i  ( lane_busy      ),
    .result_o,
    .status_o,
    .out_valid_o,
    .out_ready_i,
    .busy_o
  );

  assign tag_o = lane_tag[0];  // Lane 0 sees every word

endmodule

//--- testbench/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// ------------------------------
// Stimulus source
// ------------------------------
logic [31:0] lfsr_q = 32'h6b45;

// Fibonacci LFSR with taps 32, 22, 2, 1, one step per bit
function automatic logic [31:0] lfsr_bits(input int unsigned n);
  logic [31:0] bits;
  bits = '0;
  for (int unsigned i = 0; i < n; i++) begin
    lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
    bits   = {bits[30:0], lfsr_q[0]};
  end
  return bits;
endfunction

// Zeros, NaNs and infinities show up on purpose
function automatic fp_pkg::fp_word_t pick_operand(input logic fp16);
  logic [2:0]       kind;
  logic             sign;
  fp_pkg::fp_word_t v;
  kind = 3'(lfsr_bits(3));
  sign = 1'(lfsr_bits(1));
  case (kind)
    3'd0:    v = 32'h0;
    3'd1:    v = fp16 ? 32'h7e00 : 32'h7fc0_0000;  // Quiet NaN
    3'd2:    v = fp16 ? 32'h7c01 : 32'h7f80_0001;  // Signaling NaN
    3'd3:    v = fp16 ? 32'h7c00 : 32'h7f80_0000;  // Infinity
    default: v = lfsr_bits(32);
  endcase
  if (fp16) return {16'h0, sign, v[14:0]};
  return {sign, v[30:0]};
endfunction

// Scalar FP16 words get junk in the upper half
function automatic fp_pkg::fp_word_t make_operand(input logic fp16, input logic vec);
  logic [15:0] upper;
  logic [15:0] lower;
  if (!fp16) return pick_operand(1'b0);
  upper = vec ? 16'(pick_operand(1'b1)) : 16'(lfsr_bits(16));
  lower = 16'(pick_operand(1'b1));
  return {upper, lower};
endfunction

// ------------------------------
// Reference model
// ------------------------------
function automatic logic is_nan(input logic [31:0] x, input logic fp16);
  if (fp16) return (x[14:10] == 5'h1f) && (x[9:0] != '0);
  return (x[30:23] == 8'hff) && (x[22:0] != '0);
endfunction

function automatic logic is_snan(input logic [31:0] x, input logic fp16);
  return is_nan(x, fp16) && !(fp16 ? x[9] : x[22]);
endfunction

// Returns {nv, result}, FP16 results in the low half
function automatic logic [32:0] model_lane(input slice_pkg::operation_e op,
                                           input logic [31:0] a, input logic [31:0] b,
                                           input logic fp16);
  logic [31:0] top;
  logic [31:0] keep;
  logic [31:0] ma;
  logic [31:0] mb;
  logic [31:0] res;
  logic        sa;
  logic        sb;
  logic        nv;
  longint      ka;
  longint      kb;
  top  = fp16 ? 32'h8000 : 32'h8000_0000;
  keep = fp16 ? 32'hffff : 32'hffff_ffff;
  ma   = a & (top - 1);
  mb   = b & (top - 1);
  sa   = |(a & top);
  sb   = |(b & top);
  // Ordered keys, so -0 lands just below +0
  ka   = sa ? -longint'(ma) - 1 : longint'(ma);
  kb   = sb ? -longint'(mb) - 1 : longint'(mb);
  nv   = 1'b0;
  case (op)
    slice_pkg::MIN, slice_pkg::MAX: begin
      nv = is_snan(a, fp16) || is_snan(b, fp16);
      if (is_nan(a, fp16) && is_nan(b, fp16)) res = fp16 ? 32'h7e00 : 32'h7fc0_0000;
      else if (is_nan(a, fp16)) res = b;
      else if (is_nan(b, fp16)) res = a;
      else if (op == slice_pkg::MIN) res = (ka <= kb) ? a : b;
      else res = (ka >= kb) ? a : b;
    end
    slice_pkg::SGNJ:  res = (sb ? top : 32'h0) | ma;
    slice_pkg::SGNJN: res = (sb ? 32'h0 : top) | ma;
    default:          res = ((sa ^ sb) ? top : 32'h0) | ma;
  endcase
  return {nv, res & keep};
endfunction

function automatic expect_t model_word(input slice_pkg::operation_e op,
                                       input fp_pkg::fp_format_e fmt, input logic vec,
                                       input logic [1:0] mask, input logic [31:0] a,
                                       input logic [31:0] b, input logic [TAG_W-1:0] tag);
  logic [32:0] lo;
  logic [32:0] hi;
  logic        vector;
  expect_t     e;
  vector = vec && (fmt == fp_pkg::FP16);
  lo     = model_lane(op, a, b, fmt == fp_pkg::FP16);
  hi     = model_lane(op, a >> 16, b >> 16, 1'b1);
  e      = '0;
  if (fmt == fp_pkg::FP32) e.result = lo[31:0];
  else e.result = {vector ? hi[15:0] : 16'hffff, lo[15:0]};  // Boxed when scalar
  e.status.nv = (lo[32] & mask[0]) | (vector & hi[32] & mask[1]);
  e.tag       = tag;
  return e;
endfunction

`endif

//--- testbench/tb_fp_minmax_slice.sv
`timescale 1ns/1ps

module tb_fp_minmax_slice;

  localparam int unsigned NUM_PIPE = 2;
  localparam int unsigned TAG_W    = 8;
  localparam int unsigned TIMEOUT  = 200;

  typedef struct packed {
    fp_pkg::fp_word_t result;
    fp_pkg::status_t  status;
    logic [TAG_W-1:0] tag;
    logic             timed;  // Latency is checked
    logic [31:0]      cycle;  // Cycle of acceptance
  } expect_t;

  logic                  clk_i;
  logic                  arst_n_i;
  fp_pkg::fp_word_t      operand_a_i;
  fp_pkg::fp_word_t      operand_b_i;
  slice_pkg::operation_e op_i;
  fp_pkg::fp_format_e    fmt_i;
  logic                  vectorial_op_i;
  logic [TAG_W-1:0]      tag_i;
  logic [1:0]            simd_mask_i;
  logic                  in_valid_i;
  logic                  in_ready_o;
  logic                  flush_i;
  fp_pkg::fp_word_t      result_o;
  fp_pkg::status_t       status_o;
  logic [TAG_W-1:0]      tag_o;
  logic                  out_valid_o;
  logic                  out_ready_i;
  logic                  busy_o;

  expect_t     exp_q[$];
  expect_t     head;
  expect_t     held_out;
  expect_t     pushed;
  logic        held         = 1'b0;  // Output stalled in the last cycle
  logic        flushed      = 1'b0;
  logic        random_ready = 1'b0;
  int unsigned cycle_cnt    = 0;

  `include "tb_model.svh"

  fp_minmax_slice #(
    .NumPipeRegs ( NUM_PIPE ),
    .TagWidth    ( TAG_W    )
  ) dut0 (
    .clk_i, .arst_n_i, .operand_a_i, .operand_b_i, .op_i, .fmt_i, .vectorial_op_i,
    .tag_i, .simd_mask_i, .in_valid_i, .in_ready_o, .flush_i, .result_o, .status_o,
    .tag_o, .out_valid_o, .out_ready_i, .busy_o
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("Regression failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got == exp)
    else fail_run($sformatf("error at %0t: %s = %h, expected %h", $time, name, got, exp));
  endtask

  // ------------------------------
  // Scoreboard sampled at negedge
  // ------------------------------
  always @(negedge clk_i) begin : monitor
    if (arst_n_i && flush_i) begin
      exp_q.delete();
      held    = 1'b0;
      flushed = 1'b1;
    end else if (arst_n_i) begin
      if (flushed) begin
        assert (!out_valid_o && !busy_o)
        else fail_run("output or busy active after flush before any new input");
      end
      // Pending results are exactly the words held in the pipeline
      check_value("busy_o", 32'(busy_o), 32'(exp_q.size() != 0));
      check_value("in_ready_o", 32'(in_ready_o),
                  32'(out_ready_i || (exp_q.size() < NUM_PIPE)));
      if (held) begin
        assert (out_valid_o) else fail_run("out_valid_o dropped while stalled");
        check_value("stalled result_o", result_o, held_out.result);
        check_value("stalled status_o", 32'(status_o), 32'(held_out.status));
        check_value("stalled tag_o", 32'(tag_o), 32'(held_out.tag));
      end
      held = 1'b0;
      if (out_valid_o) begin
        assert (exp_q.size() != 0) else fail_run("output appeared with no pending input");
        head = exp_q[0];
        check_value("result_o", result_o, head.result);
        check_value("status_o", 32'(status_o), 32'(head.status));
        check_value("tag_o", 32'(tag_o), 32'(head.tag));
        if (head.timed) check_value("latency", cycle_cnt - head.cycle, NUM_PIPE);
        if (out_ready_i) void'(exp_q.pop_front());
        held     = !out_ready_i;
        held_out = head;
      end
      if (in_valid_i && in_ready_o) begin
        pushed = model_word(op_i, fmt_i, vectorial_op_i, simd_mask_i,
                            operand_a_i, operand_b_i, tag_i);
        pushed.timed = !random_ready;
        pushed.cycle = cycle_cnt;
        exp_q.push_back(pushed);
        flushed = 1'b0;
      end
    end
  end

  // ------------------------------
  // Driver tasks
  // ------------------------------
  task automatic next_cycle();
    @(posedge clk_i);
    out_ready_i <= random_ready ? (2'(lfsr_bits(2)) != 2'b00) : 1'b1;  // Mostly ready
  endtask

  task automatic send_word(input slice_pkg::operation_e op, input fp_pkg::fp_format_e fmt,
                           input logic vec, input logic [1:0] mask,
                           input fp_pkg::fp_word_t a, input fp_pkg::fp_word_t b);
    int unsigned waited;
    waited = 0;
    next_cycle();
    operand_a_i    <= a;
    operand_b_i    <= b;
    op_i           <= op;
    fmt_i          <= fmt;
    vectorial_op_i <= vec;
    simd_mask_i    <= mask;
    tag_i          <= TAG_W'(lfsr_bits(TAG_W));
    in_valid_i     <= 1'b1;
    @(negedge clk_i);
    while (!in_ready_o) begin
      waited++;
      if (waited > TIMEOUT) fail_run("input handshake timed out");
      next_cycle();
      @(negedge clk_i);
    end
  endtask

  task automatic send_random_word();
    logic                  fp16;
    logic                  vec;
    logic [1:0]            mask;
    slice_pkg::operation_e op;
    fp_pkg::fp_word_t      a;
    fp_pkg::fp_word_t      b;
    fp16 = 1'(lfsr_bits(1));
    vec  = 1'(lfsr_bits(1));
    mask = 2'(lfsr_bits(2));
    op   = slice_pkg::operation_e'(3'(lfsr_bits(3) % 5));
    a    = make_operand(fp16, vec);
    b    = make_operand(fp16, vec);
    send_word(op, fp16 ? fp_pkg::FP16 : fp_pkg::FP32, vec, mask, a, b);
  endtask

  task automatic drain();
    int unsigned waited;
    waited = 0;
    next_cycle();
    in_valid_i <= 1'b0;
    while (exp_q.size() != 0) begin
      waited++;
      if (waited > TIMEOUT) fail_run("pipeline did not drain in time");
      next_cycle();
    end
  endtask

  task automatic flush_pipe();
    next_cycle();
    in_valid_i  <= 1'b0;
    out_ready_i <= 1'b0;
    flush_i     <= 1'b1;
    next_cycle();
    flush_i <= 1'b0;
    repeat (5) next_cycle();  // Pipeline must stay empty
  endtask

  initial begin : stimulus
    operand_a_i    = '0;
    operand_b_i    = '0;
    op_i           = slice_pkg::MIN;
    fmt_i          = fp_pkg::FP32;
    vectorial_op_i = 1'b0;
    tag_i          = '0;
    simd_mask_i    = '0;
    in_valid_i     = 1'b0;
    flush_i        = 1'b0;
    out_ready_i    = 1'b1;
    arst_n_i       = 1'b0;
    repeat (10) @(posedge clk_i);
    arst_n_i <= 1'b1;
    @(negedge clk_i);
    assert (!out_valid_o && !busy_o && in_ready_o)
    else fail_run("handshake outputs not idle after reset");

    // Signed zeros, NaN pick, both signaling, sign xor, masked and boxed FP16
    send_word(slice_pkg::MIN, fp_pkg::FP32, 1'b0, 2'b01, 32'h0000_0000, 32'h8000_0000);
    send_word(slice_pkg::MAX, fp_pkg::FP32, 1'b0, 2'b01, 32'h7fc0_0001, 32'h3f80_0000);
    send_word(slice_pkg::MIN, fp_pkg::FP32, 1'b0, 2'b01, 32'h7f80_0001, 32'hff80_0001);
    send_word(slice_pkg::SGNJX, fp_pkg::FP32, 1'b0, 2'b01, 32'hbf80_0000, 32'hc000_0000);
    send_word(slice_pkg::MIN, fp_pkg::FP16, 1'b1, 2'b01, 32'h7c01_3c00, 32'h0000_4000);
    send_word(slice_pkg::MAX, fp_pkg::FP16, 1'b0, 2'b11, 32'h1234_c000, 32'hbeef_3c00);
    drain();

    for (int unsigned i = 0; i < 200; i++) send_random_word();
    drain();

    random_ready = 1'b1;  // Back-pressure
    for (int unsigned i = 0; i < 300; i++) send_random_word();
    drain();

    for (int unsigned i = 0; i < 6; i++) send_random_word();
    flush_pipe();
    random_ready = 1'b0;
    for (int unsigned i = 0; i < 20; i++) send_random_word();
    drain();

    $display("Regression passed");
    $finish;
  end

endmodule

//--- filelist.f
+incdir+testbench
design/fp_pkg.sv
design/slice_pkg.sv
design/lane_dispatch.sv
design/minmax_lane.sv
design/result_pack.sv
design/fp_minmax_slice.sv
testbench/tb_fp_minmax_slice.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator

LOG=sim.log
BUILD_DIR=obj_dir

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
  --top-module tb_fp_minmax_slice \
  -f filelist.f \
  --Mdir "$BUILD_DIR" -o sim_tb
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Regression failed" "$LOG"; then
  exit 1
fi
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi
exit 0
